/* hdl/zg_macros.svh */
// grid geometry, counter, address, pixel and output word widths
`default_nettype none

`ifndef ZG_MACROS_SVH
`define ZG_MACROS_SVH

// ============================================================
// grid geometry
// ============================================================

// side of one tile in half resolution pixels
`define ZG_TILE_DIM 100

`define ZG_COLS 4
`define ZG_ROWS 3

// ============================================================
// word widths
// ============================================================

`define ZG_CTR_W 12
`define ZG_ADR_W 14
`define ZG_PIX_W 16

// upper half is the tile row, lower half the tile column
`define ZG_TILE_W 4

`define ZG_ZRGB_W 32

`endif

`default_nettype wire

/* hdl/zg_pkg.sv */
// pixel word union with a raw view and a z/r/g/b channel view
`include "zg_macros.svh"
`default_nettype none

package zg_pkg;

	// the memory moves the raw word, the selector splits it into four channels
	typedef union packed
	{
		logic [`ZG_PIX_W-1:0] raw;
		struct packed
		{
			logic [`ZG_PIX_W/4-1:0] z;
			logic [`ZG_PIX_W/4-1:0] r;
			logic [`ZG_PIX_W/4-1:0] g;
			logic [`ZG_PIX_W/4-1:0] b;
		} ch;
	} pixel_u;

endpackage

`default_nettype wire

/* hdl/tile_wr_if.sv */
// tile memory write strobe interface with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface tile_wr_if
#(
	parameter int TILE_W = 4,
	parameter int ADR_W  = 14,
	parameter int PIX_W  = 16
);

	logic              wr;
	logic [TILE_W-1:0] tile;
	logic [ADR_W-1:0]  adr;
	logic [PIX_W-1:0]  dat;

	// single cycle strobe, no acknowledge
	modport source (output wr, output tile, output adr, output dat);

	modport sink (input wr, input tile, input adr, input dat);

endinterface

`default_nettype wire

/* hdl/scan_if.sv */
// decoded raster position interface with source and sink modports
`timescale 1ns/1ps
`default_nettype none

interface scan_if
#(
	parameter int RC_W  = 2,
	parameter int ADR_W = 14
);

	logic [RC_W-1:0]  row;
	logic [RC_W-1:0]  col;
	logic [ADR_W-1:0] adr;
	// set during blanking and also outside the tile grid
	logic             blank;

	modport source (output row, output col, output adr, output blank);

	modport sink (input row, input col, input adr, input blank);

endinterface

`default_nettype wire

/* hdl/scan_addr_gen.sv */
// raster counter decode into tile row, tile column, local address and blank flag
`timescale 1ns/1ps
`include "zg_macros.svh"
`default_nettype none

module scan_addr_gen
(
	input  wire                 dot_clk_i,
	input  wire                 arst_n_i,
	input  wire                 blank_i,
	input  wire [`ZG_CTR_W-1:0] hctr_i,
	input  wire [`ZG_CTR_W-1:0] vctr_i,
	scan_if.source              scan_o
);

	localparam int XW   = `ZG_CTR_W - 1;
	localparam int RC_W = `ZG_TILE_W / 2;
	localparam logic [XW-1:0] DIM = XW'(`ZG_TILE_DIM);

	logic [XW-1:0]        x;
	logic [XW-1:0]        y;
	logic [RC_W-1:0]      col_d;
	logic [RC_W-1:0]      row_d;
	logic [XW-1:0]        lx;
	logic [XW-1:0]        ly;
	logic [`ZG_ADR_W-1:0] adr_d;
	logic                 off_grid;

	// tiles are addressed at half resolution in both directions
	assign x = hctr_i[`ZG_CTR_W-1:1];
	assign y = vctr_i[`ZG_CTR_W-1:1];

	// ============================================================
	// tile position
	// ============================================================

	// positions past the last boundary stay clamped to the last column or row
	always_comb
	begin
		col_d = '0;
		row_d = '0;
		for (int i = 1; i < `ZG_COLS; i++)
		begin
			if (x >= DIM * XW'(i))
				col_d = RC_W'(i);
		end
		for (int i = 1; i < `ZG_ROWS; i++)
		begin
			if (y >= DIM * XW'(i))
				row_d = RC_W'(i);
		end
	end

	assign lx = x - DIM * XW'(col_d);
	assign ly = y - DIM * XW'(row_d);

	// one local address is shared by every tile
	assign adr_d = `ZG_ADR_W'(ly) * `ZG_ADR_W'(DIM) + `ZG_ADR_W'(lx);

	assign off_grid = (x >= DIM * XW'(`ZG_COLS)) || (y >= DIM * XW'(`ZG_ROWS));

	// ============================================================
	// decode register
	// ============================================================

	always_ff @(posedge dot_clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scan_o.row   <= '0;
			scan_o.col   <= '0;
			scan_o.adr   <= '0;
			scan_o.blank <= 1'b0;
		end
		else
		begin
			scan_o.row   <= row_d;
			scan_o.col   <= col_d;
			scan_o.adr   <= adr_d;
			scan_o.blank <= blank_i | off_grid;
		end
	end

endmodule

`default_nettype wire

/* hdl/tile_buffer.sv */
// per tile pixel memory with a strobed write port and a registered scan read
`timescale 1ns/1ps
`include "zg_macros.svh"
`default_nettype none

module tile_buffer
#(
	parameter int ROW = 0,
	parameter int COL = 0
)
(
	input  wire            dot_clk_i,
	tile_wr_if.sink        wr_i,
	scan_if.sink           scan_i,
	output zg_pkg::pixel_u pix_o
);

	localparam int RC_W  = `ZG_TILE_W / 2;
	localparam int DEPTH = `ZG_TILE_DIM * `ZG_TILE_DIM;
	localparam logic [`ZG_TILE_W-1:0] MY_TILE = {RC_W'(ROW), RC_W'(COL)};

	zg_pkg::pixel_u mem [0:DEPTH-1];
	logic           wr_hit;

	// only the buffer whose row and column match the tile number takes the write
	assign wr_hit = wr_i.wr
		&& (wr_i.tile == MY_TILE)
		&& (wr_i.adr < `ZG_ADR_W'(DEPTH));

	always_ff @(posedge dot_clk_i)
	begin
		if (wr_hit)
			mem[wr_i.adr].raw <= wr_i.dat;
	end

	// the scan address is read every cycle, the selector decides whether it is shown
	always_ff @(posedge dot_clk_i)
	begin
		pix_o.raw <= mem[scan_i.adr].raw;
	end

endmodule

`default_nettype wire

/* hdl/pixel_select.sv */
// tile pixel selection, blanking and expansion to the z/r/g/b output word
`timescale 1ns/1ps
`include "zg_macros.svh"
`default_nettype none

module pixel_select
(
	input  wire                    dot_clk_i,
	input  wire                    arst_n_i,
	scan_if.sink                   scan_i,
	input  wire zg_pkg::pixel_u    pix_i [0:`ZG_ROWS-1][0:`ZG_COLS-1],
	output logic [`ZG_ZRGB_W-1:0]  zrgb_o
);

	localparam int RC_W = `ZG_TILE_W / 2;

	logic [RC_W-1:0] row_q;
	logic [RC_W-1:0] col_q;
	logic            blank_q;
	zg_pkg::pixel_u  pix_sel;

	// ============================================================
	// align position with the memory read
	// ============================================================

	always_ff @(posedge dot_clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			row_q   <= '0;
			col_q   <= '0;
			blank_q <= 1'b1;
		end
		else
		begin
			row_q   <= scan_i.row;
			col_q   <= scan_i.col;
			blank_q <= scan_i.blank;
		end
	end

	always_comb
	begin
		pix_sel.raw = '0;
		if (!blank_q && (int'(row_q) < `ZG_ROWS))
			pix_sel = pix_i[row_q][col_q];
	end

	// ============================================================
	// output register
	// ============================================================

	// each channel lands in the upper nibble of its byte
	always_ff @(posedge dot_clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			zrgb_o <= '0;
		else
			zrgb_o <= {
				pix_sel.ch.z, 4'h0,
				pix_sel.ch.r, 4'h0,
				pix_sel.ch.g, 4'h0,
				pix_sel.ch.b, 4'h0
			};
	end

endmodule

`default_nettype wire

/* hdl/zg_top.sv */
// compositor top level with the scan decoder, twelve tile buffers and the pixel selector
`timescale 1ns/1ps
`include "zg_macros.svh"
`default_nettype none

module zg_top
(
	input  wire                   dot_clk_i,
	input  wire                   arst_n_i,
	input  wire                   blank_i,
	input  wire [`ZG_CTR_W-1:0]   hctr_i,
	input  wire [`ZG_CTR_W-1:0]   vctr_i,
	input  wire                   wr_i,
	input  wire [`ZG_TILE_W-1:0]  wr_tile_i,
	input  wire [`ZG_ADR_W-1:0]   wr_adr_i,
	input  wire [`ZG_PIX_W-1:0]   wr_dat_i,
	output wire [`ZG_ZRGB_W-1:0]  zrgb_o
);

	zg_pkg::pixel_u tile_pix [0:`ZG_ROWS-1][0:`ZG_COLS-1];

	// ============================================================
	// interfaces
	// ============================================================

	tile_wr_if
	#(
		.TILE_W (`ZG_TILE_W),
		.ADR_W  (`ZG_ADR_W),
		.PIX_W  (`ZG_PIX_W)
	) u_wr_if ();

	scan_if
	#(
		.RC_W  (`ZG_TILE_W / 2),
		.ADR_W (`ZG_ADR_W)
	) u_scan_if ();

	assign u_wr_if.wr   = wr_i;
	assign u_wr_if.tile = wr_tile_i;
	assign u_wr_if.adr  = wr_adr_i;
	assign u_wr_if.dat  = wr_dat_i;

	// ============================================================
	// display path
	// ============================================================

	scan_addr_gen u_scan_addr_gen
	(
		.dot_clk_i (dot_clk_i),
		.arst_n_i  (arst_n_i),
		.blank_i   (blank_i),
		.hctr_i    (hctr_i),
		.vctr_i    (vctr_i),
		.scan_o    (u_scan_if)
	);

	for (genvar r = 0; r < `ZG_ROWS; r++)
	begin : g_row
		for (genvar c = 0; c < `ZG_COLS; c++)
		begin : g_col
			tile_buffer
			#(
				.ROW (r),
				.COL (c)
			) u_tile_buffer
			(
				.dot_clk_i (dot_clk_i),
				.wr_i      (u_wr_if),
				.scan_i    (u_scan_if),
				.pix_o     (tile_pix[r][c])
			);
		end
	end

	pixel_select u_pixel_select
	(
		.dot_clk_i (dot_clk_i),
		.arst_n_i  (arst_n_i),
		.scan_i    (u_scan_if),
		.pix_i     (tile_pix),
		.zrgb_o    (zrgb_o)
	);

endmodule

`default_nettype wire

/* sim/zg_asserts.sv */
// concurrent checks on the compositor output word, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module zg_asserts
(
	input wire        dot_clk_i,
	input wire        arst_n_i,
	input wire        blank_i,
	input wire [31:0] zrgb_o
);

	// every channel sits in the upper nibble of its byte
	property low_nibbles_zero;
		@(posedge dot_clk_i) (zrgb_o & 32'h0F0F_0F0F) == 32'h0;
	endproperty

	property zero_in_reset;
		@(posedge dot_clk_i) !arst_n_i |-> (zrgb_o == 32'h0);
	endproperty

	// the output seen at an edge comes from inputs sampled three edges before it
	property blank_gives_zero;
		@(posedge dot_clk_i) disable iff (!arst_n_i)
			($past(blank_i, 3) && $past(arst_n_i, 1) && $past(arst_n_i, 2)
				&& $past(arst_n_i, 3)) |-> (zrgb_o == 32'h0);
	endproperty

	a_low_nibbles : assert property (low_nibbles_zero)
		else $error("zrgb_o has a nonzero low nibble");

	a_reset : assert property (zero_in_reset)
		else $error("zrgb_o is not zero during reset");

	a_blank : assert property (blank_gives_zero)
		else $error("zrgb_o is not zero three edges after blank_i");

endmodule

bind zg_top zg_asserts u_zg_asserts
(
	.dot_clk_i (dot_clk_i),
	.arst_n_i  (arst_n_i),
	.blank_i   (blank_i),
	.zrgb_o    (zrgb_o)
);

`default_nettype wire

/* sim/tb_zg_top.sv */
// testbench for the tiled compositor, driven from the stimulus file
`timescale 1ns/1ps
`include "zg_macros.svh"
`default_nettype none

module tb_zg_top;

	logic                   dot_clk_i;
	logic                   arst_n_i;
	logic                   blank_i;
	logic [`ZG_CTR_W-1:0]   hctr_i;
	logic [`ZG_CTR_W-1:0]   vctr_i;
	logic                   wr_i;
	logic [`ZG_TILE_W-1:0]  wr_tile_i;
	logic [`ZG_ADR_W-1:0]   wr_adr_i;
	logic [`ZG_PIX_W-1:0]   wr_dat_i;
	wire  [`ZG_ZRGB_W-1:0]  zrgb_o;

	byte         rec_kind [$];
	logic [31:0] rec_a [$];
	logic [31:0] rec_b [$];
	logic [31:0] rec_c [$];
	logic [31:0] rec_d [$];
	string       rec_name [$];

	// shadow of every written pixel, keyed by tile and local address
	int          model_mem [int];

	string cur_test;
	int    test_checks;
	int    test_errs;
	int    tests_run;
	int    tests_failed;
	int    total_checks;
	int    total_errs;
	bit    setup_err;

	zg_top u_zg_top
	(
		.dot_clk_i (dot_clk_i),
		.arst_n_i  (arst_n_i),
		.blank_i   (blank_i),
		.hctr_i    (hctr_i),
		.vctr_i    (vctr_i),
		.wr_i      (wr_i),
		.wr_tile_i (wr_tile_i),
		.wr_adr_i  (wr_adr_i),
		.wr_dat_i  (wr_dat_i),
		.zrgb_o    (zrgb_o)
	);

	initial
	begin
		dot_clk_i = 1'b0;
		forever #10 dot_clk_i = ~dot_clk_i;
	end

	// ============================================================
	// reference rules
	// ============================================================

	function automatic logic [31:0] expand_pixel(input logic [15:0] p);
		return {p[15:12], 4'h0, p[11:8], 4'h0, p[7:4], 4'h0, p[3:0], 4'h0};
	endfunction

	function automatic logic [31:0] rule_zrgb(input logic [31:0] h, input logic [31:0] v,
		input logic [31:0] b, output bit known);
		int x;
		int y;
		int key;
		x = int'(h) >> 1;
		y = int'(v) >> 1;
		known = 1'b1;
		if (b != 0 || x >= 400 || y >= 300)
			return 32'h0;
		key = ((y / 100) * 4 + x / 100) * 16384 + (y % 100) * 100 + (x % 100);
		if (!model_mem.exists(key))
		begin
			known = 1'b0;
			return 32'h0;
		end
		return expand_pixel(16'(model_mem[key]));
	endfunction

	// ============================================================
	// stimulus file
	// ============================================================

	task automatic load_stim();
		int    fd;
		int    n;
		string line;
		string rest;
		string name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("sim/zg_stim.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file sim/zg_stim.txt");
			setup_err = 1'b1;
			return;
		end
		for (n = 0; n < 1000 && !$feof(fd); n++)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 3 || line.getc(0) == "#")
				continue;
			rest = line.substr(2, line.len() - 1);
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			name = "";
			if (line.getc(0) == "T")
				void'($sscanf(rest, "%s", name));
			else
				void'($sscanf(rest, "%h %h %h %h", a, b, c, d));
			rec_kind.push_back(byte'(line.getc(0)));
			rec_name.push_back(name);
			rec_a.push_back(a);
			rec_b.push_back(b);
			rec_c.push_back(c);
			rec_d.push_back(d);
		end
		if (n >= 1000)
		begin
			$display("stimulus file did not end within 1000 lines");
			setup_err = 1'b1;
		end
		$fclose(fd);
	endtask

	// ============================================================
	// drive and check
	// ============================================================

	task automatic close_test();
		if (cur_test == "")
			return;
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %s: %s, %0d checks, %0d errors", cur_test,
			(test_errs == 0) ? "ok" : "failed", test_checks, test_errs);
		cur_test = "";
	endtask

	task automatic compare_out(input logic [31:0] h, input logic [31:0] v,
		input logic [31:0] b, input logic [31:0] exp);
		logic [31:0] model_exp;
		bit          known;
		model_exp = rule_zrgb(h, v, b, known);
		test_checks++;
		total_checks++;
		assert (known && model_exp == exp)
		else
		begin
			$display("stimulus file expects %h at h=%0d v=%0d but the pixel rules give %h",
				exp, h, v, model_exp);
			test_errs++;
			total_errs++;
		end
		assert (zrgb_o === exp)
		else
		begin
			$display("Fail at %0t ns: zrgb_o=%h, expected %h at h=%0d v=%0d blank=%0d",
				$time, zrgb_o, exp, h, v, b);
			test_errs++;
			total_errs++;
		end
	endtask

	task automatic drive_pos(input int i);
		hctr_i  = rec_a[i][`ZG_CTR_W-1:0];
		vctr_i  = rec_b[i][`ZG_CTR_W-1:0];
		blank_i = rec_c[i][0];
	endtask

	task automatic write_pixel(input int i);
		int key;
		@(negedge dot_clk_i);
		wr_i      = 1'b1;
		wr_tile_i = rec_a[i][`ZG_TILE_W-1:0];
		wr_adr_i  = rec_b[i][`ZG_ADR_W-1:0];
		wr_dat_i  = rec_c[i][`ZG_PIX_W-1:0];
		// row 3 tile numbers reach no buffer
		if (rec_a[i] < 12)
		begin
			key = int'(rec_a[i]) * 16384 + int'(rec_b[i]);
			model_mem[key] = int'(rec_c[i][15:0]);
		end
		@(negedge dot_clk_i);
		wr_i = 1'b0;
		for (int n = 0; n < 5; n++)
			@(negedge dot_clk_i);
	endtask

	task automatic check_position(input int i);
		@(negedge dot_clk_i);
		drive_pos(i);
		for (int n = 0; n < 3; n++)
			@(posedge dot_clk_i);
		@(negedge dot_clk_i);
		compare_out(rec_a[i], rec_b[i], rec_c[i], rec_d[i]);
	endtask

	// one new position per cycle, each result is compared three edges later
	task automatic check_burst(input int first, input int cnt);
		for (int t = 0; t < cnt + 3; t++)
		begin
			@(negedge dot_clk_i);
			if (t >= 3)
				compare_out(rec_a[first+t-3], rec_b[first+t-3], rec_c[first+t-3],
					rec_d[first+t-3]);
			if (t < cnt)
				drive_pos(first + t);
			else
				blank_i = 1'b1;
		end
	endtask

	initial
	begin
		int i;
		int cnt;
		int n;
		arst_n_i  = 1'b0;
		blank_i   = 1'b1;
		hctr_i    = '0;
		vctr_i    = '0;
		wr_i      = 1'b0;
		wr_tile_i = '0;
		wr_adr_i  = '0;
		wr_dat_i  = '0;
		cur_test  = "";
		load_stim();

		cur_test = "reset";
		for (n = 0; n < 16; n++)
			@(posedge dot_clk_i);
		@(negedge dot_clk_i);
		compare_out(0, 0, 1, 32'h0);
		arst_n_i = 1'b1;
		@(posedge dot_clk_i);
		@(negedge dot_clk_i);
		compare_out(0, 0, 1, 32'h0);
		close_test();

		i = 0;
		while (i < rec_kind.size())
		begin
			case (rec_kind[i])
				"T":
				begin
					close_test();
					cur_test    = rec_name[i];
					test_checks = 0;
					test_errs   = 0;
					i++;
				end
				"W":
				begin
					write_pixel(i);
					i++;
				end
				"C":
				begin
					check_position(i);
					i++;
				end
				"P":
				begin
					for (cnt = 0; i + cnt < rec_kind.size() && rec_kind[i+cnt] == "P"; cnt++)
						;
					check_burst(i, cnt);
					i += cnt;
				end
				default:
				begin
					$display("unknown record kind in the stimulus file");
					setup_err = 1'b1;
					i++;
				end
			endcase
		end
		close_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, total_checks, total_errs);
		if (total_errs == 0 && tests_failed == 0 && !setup_err)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		int n;
		for (n = 0; n < 100000; n++)
			@(posedge dot_clk_i);
		$display("simulation did not finish within 100000 cycles");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/zg_stim.txt */
# W tile adr pixel | C hctr vctr blank zrgb | P same as C, one per cycle
# T test name; all numbers in hex
T tile_addressing
W 0 0 1234
W 1 270F FFFF
W 2 0 A5C3
W 3 63 0F1E
W 4 0 2468
W 5 13BA 1357
W 6 270F 9ABC
W 7 7DA 8421
W 8 0 7777
W 9 26AC 5A5A
W A 65 C001
W B 270F 6E6E
C 0 0 0 10203040
C 18E C6 0 F0F0F0F0
C 190 0 0 A050C030
C 31E 0 0 00F010E0
C 0 C8 0 20406080
C 12C 12C 0 10305070
C 256 18E 0 90A0B0C0
C 26C F0 0 80402010
C 0 190 0 70707070
C C8 256 0 50A050A0
C 192 192 0 C0000010
C 31E 256 0 60E060E0
C 1 1 0 10203040
T channel_expansion
C 0 0 0 10203040
C 18E C6 0 F0F0F0F0
T blanking
C 0 0 1 00000000
C 320 0 0 00000000
C 0 258 0 00000000
T write_isolation
W C 0 FFFF
W F 270F 1111
W 3 0 5555
C 0 0 0 10203040
C 18E C6 0 F0F0F0F0
C 0 C8 0 20406080
C 258 0 0 50505050
C 190 0 0 A050C030
T pipelining
P 0 0 0 10203040
P 18E C6 0 F0F0F0F0
P 190 0 1 00000000
P 12C 12C 0 10305070
P 31E 256 0 60E060E0
P 320 0 0 00000000

/* files.f */
+incdir+hdl
hdl/zg_pkg.sv
hdl/tile_wr_if.sv
hdl/scan_if.sv
hdl/scan_addr_gen.sv
hdl/tile_buffer.sv
hdl/pixel_select.sv
hdl/zg_top.sv
sim/zg_asserts.sv
sim/tb_zg_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the compositor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_zg_top \
	-f files.f -o tb_zg_top

./obj_dir/tb_zg_top | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log
then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
